//--- Makefile
# Verilator build and run of the convolution layer testbench

VERILATOR ?= verilator
TOP       ?= cnn_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_TEXT ?= >>> PASS

.PHONY: sim clean

# Build, run, then look for the pass line in the output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@out=$$(./$(BUILD_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qxF '$(PASS_TEXT)'

clean:
	rm -rf $(BUILD_DIR)

//--- test/cnn_tb.sv
// Self-checking testbench that streams images into the convolution layer and checks every result word
`timescale 1ns/1ps
`include "cnn_cfg.svh"

module cnn_tb import cnn_pkg::*; ();

    localparam int W       = `CNN_WIDTH;
    localparam int K       = `CNN_KERNEL_SIZE;
    localparam int TIMEOUT = 20000;

    typedef pixel_t image_t [W][W];

    logic        clock;
    logic        reset;
    logic        in_valid;
    logic        in_ready;
    logic        out_valid;
    logic        out_last;
    logic        out_ready;
    logic [31:0] in_data;
    logic [31:0] out_data;
    logic [31:0] held_data;
    logic [31:0] rng_state = 32'hef11;
    image_t      img;
    // Expected results in stream order
    result_t     exp_q[$];
    logic        last_q[$];
    result_t     want;
    logic        want_last;
    logic        held_last;
    bit          stall_out;
    bit          hold_pending;

    cnn_top i_cnn_top (
        .clock_i     (clock),
        .reset_i     (reset),
        .in_data_i   (in_data),
        .in_valid_i  (in_valid),
        .in_ready_o  (in_ready),
        .out_data_o  (out_data),
        .out_valid_o (out_valid),
        .out_last_o  (out_last),
        .out_ready_i (out_ready)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    // LCG step with halves swapped so the low bits are the better ones
    function automatic logic [31:0] next_random();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return {rng_state[15:0], rng_state[31:16]};
    endfunction

    // Expected channels of the window whose top-left pixel is (top, left)
    function automatic result_t ref_window(input image_t im, input int top, input int left);
        result_t res;
        int      sum;
        for (int ch = 0; ch < `CNN_OUT_CHANNELS; ch++) begin
            sum = 0;
            for (int r = 0; r < K; r++) begin
                for (int c = 0; c < K; c++) begin
                    sum += int'(im[top+r][left+c]) * int'(KERNEL_WEIGHTS[ch][r][c]);
                end
            end
            sum = sum >>> `CNN_Q_SHIFT;
            // ReLU then clamp
            if (sum < 0) begin
                res[ch] = 8'h00;
            end else if (sum > 255) begin
                res[ch] = 8'hff;
            end else begin
                res[ch] = chan_result_t'(sum);
            end
        end
        return res;
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display(">>> FAIL");
        $fatal(1);
    endtask

    task automatic check_channel(input chan_result_t got, input chan_result_t exp,
                                 input string what);
        if (got !== exp) begin
            report_failure($sformatf("error at time %0t: %s is %0d, expected %0d",
                                     $time, what, got, exp));
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            report_failure($sformatf("error at time %0t: %s is %0b, expected %0b",
                                     $time, what, got, exp));
        end
    endtask

    // All pixels set to one value or all random
    task automatic fill_image(input bit random_fill, input pixel_t value);
        for (int r = 0; r < W; r++) begin
            for (int c = 0; c < W; c++) begin
                img[r][c] = random_fill ? pixel_t'(next_random()) : value;
            end
        end
    endtask

    // Queue the expected results before streaming the image in row order
    task automatic run_image(input bit gaps, input bit noisy);
        logic [31:0] rnd;
        int          waited;
        for (int r = K - 1; r < W; r++) begin
            for (int c = K - 1; c < W; c++) begin
                exp_q.push_back(ref_window(img, r - K + 1, c - K + 1));
                last_q.push_back(r == W - 1 && c == W - 1);
            end
        end
        for (int r = 0; r < W; r++) begin
            for (int c = 0; c < W; c++) begin
                rnd      = next_random();
                // Upper bytes are noise the DUT must ignore
                in_data  = noisy ? {rnd[31:8], img[r][c]} : {24'h0, img[r][c]};
                in_valid = 1'b1;
                waited   = 0;
                @(posedge clock);
                while (!in_ready) begin
                    waited++;
                    if (waited > TIMEOUT) begin
                        report_failure("timed out waiting for in_ready_o to accept a pixel");
                    end
                    @(posedge clock);
                end
                @(negedge clock);
                in_valid = 1'b0;
                if (gaps && next_random() % 4 == 0) begin
                    repeat (next_random() % 3 + 1) @(negedge clock);
                end
            end
        end
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0) begin
            waited++;
            if (waited > TIMEOUT) begin
                report_failure("timed out waiting for the remaining results");
            end
            @(negedge clock);
        end
    endtask

    // Compare every accepted result and check stalled results for stability
    always @(posedge clock) begin
        if (!reset) begin
            if (hold_pending) begin
                check_flag(out_valid, 1'b1, "stalled out_valid_o");
                check_channel(out_data[7:0], held_data[7:0], "stalled channel 0");
                check_channel(out_data[23:16], held_data[23:16], "stalled channel 1");
                check_flag(out_last, held_last, "stalled out_last_o");
            end
            if (out_valid && out_ready) begin
                if (exp_q.size() == 0) begin
                    report_failure("the DUT produced a result that no window accounts for");
                end
                want      = exp_q.pop_front();
                want_last = last_q.pop_front();
                check_channel(out_data[7:0], want[0], "channel 0");
                check_channel(out_data[23:16], want[1], "channel 1");
                check_channel(out_data[15:8], 8'h00, "channel 0 upper byte");
                check_channel(out_data[31:24], 8'h00, "channel 1 upper byte");
                check_flag(out_last, want_last, "out_last_o");
            end
            hold_pending = out_valid && !out_ready;
            held_data    = out_data;
            held_last    = out_last;
        end
    end

    // Result sink drops ready about a quarter of the time when stalling
    initial begin
        logic ready_next;
        forever begin
            // Decided on the rising edge, driven on the falling edge
            @(posedge clock);
            ready_next = !reset && (!stall_out || next_random() % 4 != 0);
            @(negedge clock);
            out_ready = ready_next;
        end
    end

    initial begin
        reset        = 1'b1;
        in_data      = '0;
        in_valid     = 1'b0;
        out_ready    = 1'b0;
        stall_out    = 1'b0;
        hold_pending = 1'b0;
        repeat (16) @(negedge clock);
        reset = 1'b0;
        @(negedge clock);
        check_flag(in_ready, 1'b1, "in_ready_o after reset");
        check_flag(out_valid, 1'b0, "out_valid_o after reset");

        // Known images of zeros, of full scale and with one bright pixel
        fill_image(1'b0, 8'h00);
        run_image(1'b0, 1'b0);
        wait_drain();
        fill_image(1'b0, 8'hff);
        run_image(1'b0, 1'b0);
        wait_drain();
        fill_image(1'b0, 8'h00);
        img[13][13] = 8'hff;
        run_image(1'b0, 1'b0);
        wait_drain();

        // Two random images back to back
        fill_image(1'b1, 8'h00);
        run_image(1'b0, 1'b1);
        fill_image(1'b1, 8'h00);
        run_image(1'b0, 1'b1);
        wait_drain();

        // Input gaps plus output back-pressure
        stall_out = 1'b1;
        fill_image(1'b1, 8'h00);
        run_image(1'b1, 1'b1);
        fill_image(1'b1, 8'h00);
        run_image(1'b1, 1'b1);
        wait_drain();
        stall_out = 1'b0;
        // Idle tail catches any extra result
        repeat (20) @(negedge clock);

        $display(">>> PASS");
        $finish;
    end

endmodule

//--- verilog.f
+incdir+verilog
verilog/cnn_pkg.sv
verilog/conv_window_if.sv
verilog/shift_buffer_array.sv
verilog/conv_kernel.sv
verilog/cnn_layer.sv
verilog/cnn_top.sv
test/cnn_tb.sv

//--- verilog/cnn_cfg.svh
// Layer dimensions and fixed-point settings, included by the package and every RTL file
`ifndef CNN_CFG_SVH
`define CNN_CFG_SVH

// Square image side in pixels
`define CNN_WIDTH 28

// Grayscale pixel width
`define CNN_PIXEL_BITS 8

// Square convolution window side
`define CNN_KERNEL_SIZE 3

// Output channels computed per window
`define CNN_OUT_CHANNELS 2

// Arithmetic right shift applied to each channel sum
`define CNN_Q_SHIFT 3

// Signed weight width
`define CNN_WEIGHT_BITS 8

`endif

//--- verilog/cnn_layer.sv
// Convolution layer core, tracks pixel position and feeds windows from the buffer to the kernel
`timescale 1ns/1ps
`include "cnn_cfg.svh"

module cnn_layer import cnn_pkg::*; (
    input  logic    clock_i,
    input  logic    reset_i,
    input  pixel_t  pixel_i,
    input  logic    pixel_valid_i,
    output logic    pixel_ready_o,
    output result_t result_o,
    output logic    result_valid_o,
    output logic    result_last_o,
    input  logic    result_ready_i
);

    localparam int W        = `CNN_WIDTH;
    localparam int CNT_BITS = $clog2(W);

    // Position of the next incoming pixel
    logic [CNT_BITS-1:0] row_q;
    logic [CNT_BITS-1:0] col_q;

    logic win_valid_q;
    logic win_last_q;
    logic accept;
    logic row_end;
    logic win_full;

    conv_window_if win_if ();

    // Stall only while a window waits on the kernel
    assign pixel_ready_o = !win_valid_q || win_if.win_ready;
    assign accept        = pixel_valid_i && pixel_ready_o;
    assign row_end       = (col_q == CNT_BITS'(W - 1));
    // Enough rows and columns behind this pixel for a full window
    assign win_full      = (row_q >= CNT_BITS'(`CNN_KERNEL_SIZE - 1)) &&
                           (col_q >= CNT_BITS'(`CNN_KERNEL_SIZE - 1));

    assign win_if.win_valid = win_valid_q;
    assign win_if.win_last  = win_last_q;

    // Counters and window flags
    always_ff @(posedge clock_i) begin
        if (reset_i) begin
            row_q       <= '0;
            col_q       <= '0;
            win_valid_q <= 1'b0;
            win_last_q  <= 1'b0;
        end else if (accept) begin
            col_q <= row_end ? '0 : col_q + 1'b1;
            if (row_end) begin
                // Wrap straight into the next image
                row_q <= (row_q == CNT_BITS'(W - 1)) ? '0 : row_q + 1'b1;
            end
            win_valid_q <= win_full;
            win_last_q  <= row_end && (row_q == CNT_BITS'(W - 1));
        end else if (win_if.win_ready) begin
            win_valid_q <= 1'b0;
        end
    end

    shift_buffer_array i_shift_buffer_array (
        .clock_i  (clock_i),
        .shift_i  (accept),
        .pixel_i  (pixel_i),
        .window_o (win_if.window)
    );

    conv_kernel i_conv_kernel (
        .clock_i        (clock_i),
        .reset_i        (reset_i),
        .win            (win_if.consumer),
        .result_o       (result_o),
        .result_valid_o (result_valid_o),
        .result_last_o  (result_last_o),
        .result_ready_i (result_ready_i)
    );

endmodule

//--- verilog/cnn_pkg.sv
// Shared data types and the constant kernel weights of the convolution layer
`include "cnn_cfg.svh"

package cnn_pkg;

    // One grayscale sample, unsigned
    typedef logic [`CNN_PIXEL_BITS-1:0] pixel_t;

    // Kernel coefficient, two's complement
    typedef logic signed [`CNN_WEIGHT_BITS-1:0] weight_t;

    // Nine 8x8 products fit easily in 16 bits
    typedef logic signed [15:0] acc_t;

    // Row-major window, index 0 is the oldest row and oldest column
    typedef pixel_t [0:`CNN_KERNEL_SIZE-1][0:`CNN_KERNEL_SIZE-1] window_t;

    // Clamped result of one channel
    typedef logic [7:0] chan_result_t;

    // All channels of one window position
    typedef chan_result_t [0:`CNN_OUT_CHANNELS-1] result_t;

    // Channel 0 Laplacian edge detector, channel 1 box sum
    localparam weight_t KERNEL_WEIGHTS
        [`CNN_OUT_CHANNELS][`CNN_KERNEL_SIZE][`CNN_KERNEL_SIZE] = '{
        '{'{-8'sd1, -8'sd1, -8'sd1},
          '{-8'sd1,  8'sd8, -8'sd1},
          '{-8'sd1, -8'sd1, -8'sd1}},
        '{'{ 8'sd1,  8'sd1,  8'sd1},
          '{ 8'sd1,  8'sd1,  8'sd1},
          '{ 8'sd1,  8'sd1,  8'sd1}}
    };

endpackage

//--- verilog/cnn_top.sv
// Top level of the convolution layer with 32-bit stream ports for pixels in and results out
`timescale 1ns/1ps
`include "cnn_cfg.svh"

module cnn_top import cnn_pkg::*; (
    input  logic        clock_i,
    input  logic        reset_i,
    // Pixel stream, one sample in the low byte
    input  logic [31:0] in_data_i,
    input  logic        in_valid_i,
    output logic        in_ready_o,
    // Result stream, 16 bits per channel
    output logic [31:0] out_data_o,
    output logic        out_valid_o,
    output logic        out_last_o,
    input  logic        out_ready_i
);

    pixel_t  pixel;
    result_t result;

    // Upper bits of the input word are don't-care
    assign pixel = in_data_i[`CNN_PIXEL_BITS-1:0];

    // Channel n lands in bits 16n+15 down to 16n, zero-extended
    always_comb begin
        out_data_o = '0;
        for (int ch = 0; ch < `CNN_OUT_CHANNELS; ch++) begin
            out_data_o[ch*16 +: 16] = {8'h00, result[ch]};
        end
    end

    cnn_layer i_cnn_layer (
        .clock_i        (clock_i),
        .reset_i        (reset_i),
        .pixel_i        (pixel),
        .pixel_valid_i  (in_valid_i),
        .pixel_ready_o  (in_ready_o),
        .result_o       (result),
        .result_valid_o (out_valid_o),
        .result_last_o  (out_last_o),
        .result_ready_i (out_ready_i)
    );

endmodule

//--- verilog/conv_kernel.sv
// Two-stage multiply-accumulate and requantize pipeline producing both output channels per window
`timescale 1ns/1ps
`include "cnn_cfg.svh"

module conv_kernel import cnn_pkg::*; (
    input  logic                  clock_i,
    input  logic                  reset_i,
    conv_window_if.consumer       win,
    output result_t               result_o,
    output logic                  result_valid_o,
    output logic                  result_last_o,
    input  logic                  result_ready_i
);

    localparam int K = `CNN_KERNEL_SIZE;
    localparam int C = `CNN_OUT_CHANNELS;

    // Weighted sum of one channel over the window
    function automatic acc_t channel_sum(input window_t w, input int ch);
        acc_t sum;
        acc_t prod;
        sum = '0;
        for (int r = 0; r < K; r++) begin
            for (int c = 0; c < K; c++) begin
                // Zero-extend pixel so the product stays signed
                prod = $signed({1'b0, w[r][c]}) * KERNEL_WEIGHTS[ch][r][c];
                sum = sum + prod;
            end
        end
        return sum;
    endfunction

    // Shift, ReLU, then saturate to 8 bits
    function automatic chan_result_t requant(input acc_t sum);
        acc_t shifted;
        chan_result_t res;
        shifted = sum >>> `CNN_Q_SHIFT;
        if (shifted < 0) begin
            res = '0;
        end else if (shifted > acc_t'(255)) begin
            res = 8'hff;
        end else begin
            res = shifted[7:0];
        end
        return res;
    endfunction

    // Stage 1, per-channel sums
    logic s1_valid_q;
    logic s1_last_q;
    acc_t s1_sum_q [C];

    // Stage 2, final channel values
    logic    s2_valid_q;
    logic    s2_last_q;
    result_t s2_res_q;

    // Advance when empty or when downstream moves
    logic s1_adv;
    logic s2_adv;

    assign s2_adv = !s2_valid_q || result_ready_i;
    assign s1_adv = !s1_valid_q || s2_adv;

    // Window is taken whenever stage 1 can load
    assign win.win_ready = s1_adv;

    // Stage valid bits
    always_ff @(posedge clock_i) begin
        if (reset_i) begin
            s1_valid_q <= 1'b0;
            s2_valid_q <= 1'b0;
        end else begin
            if (s1_adv) begin
                s1_valid_q <= win.win_valid;
            end
            if (s2_adv) begin
                s2_valid_q <= s1_valid_q;
            end
        end
    end

    // Payload, loaded on advance only so stalled data holds
    always_ff @(posedge clock_i) begin
        if (s1_adv) begin
            s1_last_q <= win.win_last;
            for (int ch = 0; ch < C; ch++) begin
                s1_sum_q[ch] <= channel_sum(win.window, ch);
            end
        end
        if (s2_adv) begin
            s2_last_q <= s1_last_q;
            for (int ch = 0; ch < C; ch++) begin
                s2_res_q[ch] <= requant(s1_sum_q[ch]);
            end
        end
    end

    assign result_o       = s2_res_q;
    assign result_valid_o = s2_valid_q;
    // Only meaningful alongside valid
    assign result_last_o  = s2_last_q;

endmodule

//--- verilog/conv_window_if.sv
// Window stream between the layer control and the kernel pipeline, with valid/ready handshake
`timescale 1ns/1ps

interface conv_window_if import cnn_pkg::*; ();

    // Current 3x3 neighbourhood from the line buffers
    window_t window;
    // Window holds a complete valid position
    logic    win_valid;
    // Final window of the image
    logic    win_last;
    // Kernel can take the window this cycle
    logic    win_ready;

    // Layer side, window comes from the buffer and flags from the counters
    modport producer (
        output window, win_valid, win_last,
        input  win_ready
    );

    // Kernel side
    modport consumer (
        input  window, win_valid, win_last,
        output win_ready
    );

endinterface

//--- verilog/shift_buffer_array.sv
// Line buffers and window registers that turn a row-order pixel stream into 3x3 windows
`timescale 1ns/1ps
`include "cnn_cfg.svh"

module shift_buffer_array import cnn_pkg::*; (
    input  logic    clock_i,
    // Advance everything by one pixel
    input  logic    shift_i,
    input  pixel_t  pixel_i,
    output window_t window_o
);

    localparam int K = `CNN_KERNEL_SIZE;
    localparam int W = `CNN_WIDTH;

    // K-1 delay lines of one image row each
    pixel_t line_q [K-1][W];

    // Input of each delay line
    pixel_t line_in [K-1];

    // Newest column of the window, index 0 the oldest row
    pixel_t col_new [K];

    // Line 0 takes the stream, each further line takes the tail of the previous one
    always_comb begin
        line_in[0] = pixel_i;
        for (int r = 1; r < K - 1; r++) begin
            line_in[r] = line_q[r-1][W-1];
        end
    end

    // Tail of line r is the same column r+1 rows up
    always_comb begin
        col_new[K-1] = pixel_i;
        for (int r = 0; r < K - 1; r++) begin
            col_new[K-2-r] = line_q[r][W-1];
        end
    end

    // Delay lines, plain shift registers
    always_ff @(posedge clock_i) begin
        if (shift_i) begin
            for (int r = 0; r < K - 1; r++) begin
                line_q[r][0] <= line_in[r];
                for (int c = 1; c < W; c++) begin
                    line_q[r][c] <= line_q[r][c-1];
                end
            end
        end
    end

    // Window registers move left one column per pixel
    always_ff @(posedge clock_i) begin
        if (shift_i) begin
            for (int r = 0; r < K; r++) begin
                for (int c = 0; c < K - 1; c++) begin
                    window_o[r][c] <= window_o[r][c+1];
                end
                // Rightmost column gets the fresh vertical slice
                window_o[r][K-1] <= col_new[r];
            end
        end
    end

    // Contents are garbage until two rows are in
    // but the layer never flags a window that early

endmodule
